// File: verif/mov_cases.txt
# name ninstr nbytes byte0..byte7 nwrites, then two writes as address data word
# numbers are hex, unused bytes and writes are zero
imm_word_store  2 5 b8 34 12 89 07 00 00 00 1 00000 1234 1 00000 0000 0
byte_lane_merge 3 8 b4 ab b0 cd 89 06 20 00 1 00020 abcd 1 00000 0000 0
byte_store      3 8 b3 40 88 27 88 1e 30 00 2 00040 00ab 0 00030 0040 0
read_disp8      2 7 8b 4f 10 89 0e 60 00 00 1 00060 a593 1 00000 0000 0
read_disp16     2 8 8b 97 00 01 89 16 70 00 1 00070 a483 1 00000 0000 0
negative_disp8  2 6 8a 47 f0 89 47 80 00 00 1 0ffc0 abf3 1 00000 0000 0
load_ds         3 7 b9 00 10 8e d9 89 07 00 1 10040 abf3 1 00000 0000 0
bp_uses_ss      3 8 b8 00 20 8e d0 89 56 04 1 20004 a483 1 00000 0000 0
store_sreg      2 8 8c 1e 10 00 8c 16 12 00 2 10010 1000 1 10012 2000 1
imm_mem_word    2 8 be 02 00 c7 40 06 ef be 1 10048 beef 1 00000 0000 0
imm_mem_byte    2 8 bf 10 00 c6 83 00 02 5a 1 20210 005a 0 00000 0000 0
noop_between    2 8 90 b2 77 40 88 16 80 00 1 10080 0077 0 00000 0000 0
reg_to_reg      4 8 8b c8 89 0f 8a e2 88 27 2 10040 2000 1 10040 0077 0

// File: verilog.f
source/isa_pkg.sv
source/bus_pkg.sv
source/instr_if.sv
source/regfile_if.sv
source/decode_stage.sv
source/execute_stage.sv
source/register_file.sv
source/execution_unit.sv
verif/execution_unit_properties.sv
verif/execution_unit_checker.sv
verif/execution_unit_tb.sv

// File: verif/execution_unit_tb.sv
`timescale 1ns/1ps

module execution_unit_tb
    import bus_pkg::*;
();

    localparam int WAIT_LIMIT = 500;

    logic              clk;
    logic              reset;
    logic [7:0]        prefetch_data;
    logic              queue_empty;
    logic              queue_pop;
    logic [1:0]        bus_command;
    logic [ADDR_W-1:0] bus_address;
    logic [15:0]       bus_data_out;
    logic              bus_word;
    logic [15:0]       bus_data_in;
    logic              bus_command_done;
    logic              instruction_done;

    // bytes still in the prefetch queue, the head sits on prefetch_data
    logic [7:0]        feed_q [$];
    logic [31:0]       rng_state;
    logic [31:0]       queue_rnd;
    logic [31:0]       mem_rnd;
    logic              popped;
    int                mem_delay;

    // fields of one case line
    int                fd;
    string             line;
    string             name;
    int                n_fields;
    int                ninstr;
    int                nbytes;
    int                nwrites;
    logic [7:0]        case_bytes [8];
    logic [ADDR_W-1:0] wr_addr [2];
    logic [15:0]       wr_data [2];
    logic              wr_word [2];
    int                target_done;
    int                case_count;
    bit                timed_out;
    bit                bad_file;
    int                total_errors;

    execution_unit dut_i (
        .clk              (clk),
        .reset            (reset),
        .prefetch_data    (prefetch_data),
        .queue_empty      (queue_empty),
        .queue_pop        (queue_pop),
        .bus_command      (bus_command),
        .bus_address      (bus_address),
        .bus_data_out     (bus_data_out),
        .bus_word         (bus_word),
        .bus_data_in      (bus_data_in),
        .bus_command_done (bus_command_done),
        .instruction_done (instruction_done)
    );

    execution_unit_checker checker_i (
        .clk              (clk),
        .reset            (reset),
        .bus_command      (bus_command),
        .bus_address      (bus_address),
        .bus_data_out     (bus_data_out),
        .bus_word         (bus_word),
        .bus_command_done (bus_command_done),
        .instruction_done (instruction_done)
    );

    bind execution_unit execution_unit_properties properties_i (
        .clk              (clk),
        .reset            (reset),
        .queue_empty      (queue_empty),
        .queue_pop        (queue_pop),
        .bus_command      (bus_command),
        .bus_command_done (bus_command_done),
        .instruction_done (instruction_done)
    );

    always #4 clk = ~clk;

    function automatic logic [31:0] lcg_next();
        rng_state = rng_state * 32'd1664525 + 32'd1013904223;
        return rng_state;
    endfunction

    // pop request is sampled mid cycle, ahead of the edge that takes the byte
    always @(negedge clk)
        popped = (queue_pop === 1'b1);

    // queue model, stalls about one cycle in four
    always @(posedge clk)
    begin
        #1;
        if (popped && feed_q.size() > 0)
            void'(feed_q.pop_front());
        queue_rnd = lcg_next();
        if (!reset && feed_q.size() > 0 && queue_rnd[17:16] != 2'b00)
        begin
            queue_empty   = 1'b0;
            prefetch_data = feed_q[0];
        end
        else
        begin
            queue_empty   = 1'b1;
            prefetch_data = 8'h00;
        end
    end

    // memory model, done after 1..4 cycles
    initial
    begin
        forever
        begin
            @(negedge clk);
            if (!reset && bus_command != BUS_IDLE && !bus_command_done)
            begin
                mem_rnd   = lcg_next();
                mem_delay = 1 + mem_rnd[17:16];
                repeat (mem_delay)
                    @(posedge clk);
                #1;
                // low 16 address bits xor a5c3
                bus_data_in      = bus_address[15:0] ^ 16'ha5c3;
                bus_command_done = 1'b1;
                @(posedge clk);
                #1;
                bus_command_done = 1'b0;
                bus_data_in      = 16'h0000;
            end
        end
    end

    task automatic wait_for_done(input string case_name);
        int cycles;
        cycles = 0;
        while (checker_i.done_count < target_done && cycles < WAIT_LIMIT)
        begin
            @(negedge clk);
            cycles++;
        end
        if (checker_i.done_count < target_done)
        begin
            $display("timeout waiting for instruction_done in case %s", case_name);
            timed_out = 1'b1;
        end
    endtask

    task automatic wait_for_idle();
        int cycles;
        cycles = 0;
        while ((feed_q.size() != 0 || bus_command != BUS_IDLE) && cycles < WAIT_LIMIT)
        begin
            @(negedge clk);
            cycles++;
        end
        if (feed_q.size() != 0 || bus_command != BUS_IDLE)
        begin
            $display("timeout waiting for the queue to drain and the bus to go idle");
            timed_out = 1'b1;
        end
    endtask

    // one line: name, counts, eight bytes, two writes
    task automatic run_case_line(input string text);
        n_fields = $sscanf(text, "%s %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                           name, ninstr, nbytes,
                           case_bytes[0], case_bytes[1], case_bytes[2], case_bytes[3],
                           case_bytes[4], case_bytes[5], case_bytes[6], case_bytes[7],
                           nwrites, wr_addr[0], wr_data[0], wr_word[0],
                           wr_addr[1], wr_data[1], wr_word[1]);
        if (n_fields != 18)
        begin
            $display("case line could not be parsed: %s", text);
            bad_file = 1'b1;
        end
        else
        begin
            for (int i = 0; i < nwrites; i++)
                checker_i.expect_write(name, wr_addr[i], wr_data[i], wr_word[i]);
            for (int i = 0; i < nbytes; i++)
                feed_q.push_back(case_bytes[i]);
            target_done += ninstr;
            case_count++;
            wait_for_done(name);
        end
    endtask

    initial
    begin
        clk              = 1'b0;
        reset            = 1'b1;
        prefetch_data    = 8'h00;
        queue_empty      = 1'b1;
        bus_data_in      = 16'h0000;
        bus_command_done = 1'b0;
        rng_state        = 32'h106d;
        popped           = 1'b0;
        target_done      = 0;
        case_count       = 0;
        timed_out        = 1'b0;
        bad_file         = 1'b0;
        fd = $fopen("verif/mov_cases.txt", "r");
        if (fd == 0)
        begin
            $display("cannot open verif/mov_cases.txt");
            bad_file = 1'b1;
        end
        repeat (5)
            @(posedge clk);
        #1;
        reset = 1'b0;
        // cases are queued mid cycle, away from the queue model's updates
        @(negedge clk);
        while (!bad_file && !timed_out && !$feof(fd))
        begin
            line = "";
            void'($fgets(line, fd));
            if (line.len() > 1 && line.getc(0) != "#")
                run_case_line(line);
        end
        if (!bad_file && !timed_out)
            wait_for_idle();
        if (fd != 0)
            $fclose(fd);
        checker_i.check_totals(target_done);
        total_errors = checker_i.error_count + dut_i.properties_i.fail_count;
        $display("cases %0d, instructions %0d of %0d, writes %0d, errors %0d, assertions %0d",
                 case_count, checker_i.done_count, target_done, checker_i.write_count,
                 checker_i.error_count, dut_i.properties_i.fail_count);
        if (total_errors == 0 && !timed_out && !bad_file && case_count > 0)
            $display("TEST PASS");
        else
            $display("TEST FAIL");
        $finish;
    end

endmodule

// File: verif/execution_unit_checker.sv
`timescale 1ns/1ps

module execution_unit_checker
    import bus_pkg::*;
(
    input logic              clk,
    input logic              reset,
    input logic [1:0]        bus_command,
    input logic [ADDR_W-1:0] bus_address,
    input logic [15:0]       bus_data_out,
    input logic              bus_word,
    input logic              bus_command_done,
    input logic              instruction_done
);

    // expected writes in program order, each tagged with its case name
    string             exp_name [$];
    logic [ADDR_W-1:0] exp_addr [$];
    logic [15:0]       exp_data [$];
    logic              exp_word [$];

    int error_count = 0;
    int write_count = 0;
    int done_count  = 0;

    task automatic expect_write(input string name, input logic [ADDR_W-1:0] addr,
                                input logic [15:0] data, input logic word);
        exp_name.push_back(name);
        exp_addr.push_back(addr);
        exp_data.push_back(data);
        exp_word.push_back(word);
    endtask

    task automatic compare_field(input string name, input string field,
                                 input logic [ADDR_W-1:0] expected,
                                 input logic [ADDR_W-1:0] actual);
        if (actual !== expected)
        begin
            $display("error %s %s: expected %0h actual %0h", name, field, expected, actual);
            error_count++;
        end
    endtask

    // a write lands on the edge where done is seen with the command
    always @(posedge clk)
    begin
        if (!reset && instruction_done)
            done_count <= done_count + 1;
        if (!reset && (bus_command == BUS_WRITE) && bus_command_done)
        begin
            write_count++;
            if (exp_addr.size() == 0)
            begin
                $display("unexpected bus write to %0h with data %0h", bus_address, bus_data_out);
                error_count++;
            end
            else
            begin
                compare_field(exp_name[0], "address", exp_addr[0], bus_address);
                compare_field(exp_name[0], "data", {4'h0, exp_data[0]}, {4'h0, bus_data_out});
                compare_field(exp_name[0], "word flag", {19'h0, exp_word[0]}, {19'h0, bus_word});
                void'(exp_name.pop_front());
                void'(exp_addr.pop_front());
                void'(exp_data.pop_front());
                void'(exp_word.pop_front());
            end
        end
    end

    // run totals against the case file
    task automatic check_totals(input int expected_instr);
        if (done_count != expected_instr)
        begin
            $display("error instruction_count: expected %0d actual %0d",
                     expected_instr, done_count);
            error_count++;
        end
        if (exp_addr.size() != 0)
        begin
            $display("%0d expected bus writes never happened, first one from case %s",
                     exp_addr.size(), exp_name[0]);
            error_count++;
        end
    endtask

endmodule

// File: verif/execution_unit_properties.sv
`timescale 1ns/1ps

module execution_unit_properties
    import bus_pkg::*;
(
    input logic       clk,
    input logic       reset,
    input logic       queue_empty,
    input logic       queue_pop,
    input logic [1:0] bus_command,
    input logic       bus_command_done,
    input logic       instruction_done
);

    int fail_count = 0;

    // a pending command only changes on the edge that completes it
    command_held : assert property (@(posedge clk) disable iff (reset)
        ((bus_command != BUS_IDLE) && !bus_command_done) |=> $stable(bus_command))
    else
    begin
        fail_count++;
        $error("bus command changed while waiting for bus_command_done");
    end

    // decode only leaves a waiting byte in the queue while execute is busy
    stall_only_when_busy : assert property (@(posedge clk) disable iff (reset)
        (!queue_empty && !queue_pop) |=> ((bus_command != BUS_IDLE) || instruction_done))
    else
    begin
        fail_count++;
        $error("queue_pop held low with a byte waiting while execute was idle");
    end

    // reset clears the done pulse
    done_quiet_in_reset : assert property (@(posedge clk) reset |=> !instruction_done)
    else
    begin
        fail_count++;
        $error("instruction_done high during reset");
    end

endmodule

// File: source/execution_unit.sv
`timescale 1ns/1ps

module execution_unit
    import isa_pkg::*;
    import bus_pkg::*;
(
    input  logic              clk,
    input  logic              reset,

    // prefetch queue
    input  logic [BYTE_W-1:0] prefetch_data,
    input  logic              queue_empty,
    output logic              queue_pop,

    // memory bus
    output logic [1:0]        bus_command,
    output logic [ADDR_W-1:0] bus_address,
    output logic [DATA_W-1:0] bus_data_out,
    output logic              bus_word,
    input  logic [DATA_W-1:0] bus_data_in,
    input  logic              bus_command_done,

    output logic              instruction_done
);

    // decoded instruction from decode to execute
    instr_if   instr_bus ();
    // register reads and writeback
    regfile_if regs_bus ();

    decode_stage decode_i (
        .clk           (clk),
        .reset         (reset),
        .prefetch_data (prefetch_data),
        .queue_empty   (queue_empty),
        .queue_pop     (queue_pop),
        .instr         (instr_bus.driver)
    );

    execute_stage execute_i (
        .clk              (clk),
        .reset            (reset),
        .instr            (instr_bus.receiver),
        .regs             (regs_bus.driver),
        .bus_command      (bus_command),
        .bus_address      (bus_address),
        .bus_data_out     (bus_data_out),
        .bus_word         (bus_word),
        .bus_data_in      (bus_data_in),
        .bus_command_done (bus_command_done),
        .instruction_done (instruction_done)
    );

    register_file regfile_i (
        .clk   (clk),
        .reset (reset),
        .regs  (regs_bus.receiver)
    );

endmodule

// File: source/register_file.sv
`timescale 1ns/1ps

module register_file
    import isa_pkg::*;
(
    input  logic       clk,
    input  logic       reset,
    regfile_if.receiver regs
);

    // aw cw dw bw sp bp ix iy
    logic [DATA_W-1:0] gpr [0:(1 << REG_ID_W)-1];
    // es cs ss ds
    logic [DATA_W-1:0] sreg [0:(1 << SREG_ID_W)-1];
    logic [REG_ID_W-1:0] lane_reg;

    // read ports are plain lookups
    assign regs.src_data   = gpr[regs.src_id];
    assign regs.base_data  = gpr[regs.base_id];
    assign regs.index_data = gpr[regs.index_id];
    assign regs.seg_data   = sreg[regs.seg_id];

    // byte ids 4..7 are the high halves of aw..bw
    assign lane_reg = {1'b0, regs.wr_id[1:0]};

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            for (int i = 0; i < (1 << REG_ID_W); i++)
                gpr[i] <= '0;
            for (int i = 0; i < (1 << SREG_ID_W); i++)
                sreg[i] <= '0;
        end
        else if (regs.we)
        begin
            if (regs.is_sreg)
                sreg[regs.wr_id[SREG_ID_W-1:0]] <= regs.wr_data;
            else if (regs.wr_word)
                gpr[regs.wr_id] <= regs.wr_data;
            // byte write keeps the other lane
            else if (regs.wr_id[2])
                gpr[lane_reg][15:8] <= regs.wr_data[7:0];
            else
                gpr[lane_reg][7:0] <= regs.wr_data[7:0];
        end
    end

endmodule

// File: source/execute_stage.sv
`timescale 1ns/1ps

module execute_stage
    import isa_pkg::*;
    import bus_pkg::*;
(
    input  logic              clk,
    input  logic              reset,
    instr_if.receiver         instr,
    regfile_if.driver         regs,
    output logic [1:0]        bus_command,
    output logic [ADDR_W-1:0] bus_address,
    output logic [DATA_W-1:0] bus_data_out,
    output logic              bus_word,
    input  logic [DATA_W-1:0] bus_data_in,
    input  logic              bus_command_done,
    output logic              instruction_done
);

    logic                 exec_q;
    logic                 word_q;
    logic [1:0]           dst_kind_q;
    logic [REG_ID_W-1:0]  dst_id_q;
    logic                 mem_q;
    logic [4:0]           ea_mode_q;
    logic [DATA_W-1:0]    disp_q;
    logic [DATA_W-1:0]    src_val_q;
    logic                 transfer;
    logic [DATA_W-1:0]    src_lane;
    logic [DATA_W-1:0]    src_value;
    logic [1:0]           mod;
    logic [2:0]           rm;
    logic                 direct;
    logic                 use_base;
    logic                 use_index;
    logic [REG_ID_W-1:0]  base_id;
    logic [SREG_ID_W-1:0] ea_seg;
    logic [DATA_W-1:0]    eff_addr;
    logic [ADDR_W-1:0]    phys_addr;
    logic                 bus_finish;

    // busy from transfer until the done edge
    assign instr.ready = !exec_q && (bus_command == BUS_IDLE);
    assign transfer    = instr.valid && instr.ready;

    // source is read in the transfer cycle, while seg_id is still free
    assign regs.src_id = instr.word ? instr.reg_id : {1'b0, instr.reg_id[1:0]};

    always_comb
    begin
        if (instr.word)
            src_lane = regs.src_data;
        else if (instr.reg_id[2])
            src_lane = {8'h00, regs.src_data[15:8]};
        else
            src_lane = {8'h00, regs.src_data[7:0]};
    end

    always_comb
    begin
        case (instr.src_kind)
            SRC_IMM:  src_value = instr.imm;
            SRC_SREG: src_value = regs.seg_data;
            SRC_REG:  src_value = src_lane;
            // memory data arrives later on the bus
            default:  src_value = '0;
        endcase
    end

    // effective address from the rm table
    assign mod       = ea_mode_q[4:3];
    assign rm        = ea_mode_q[2:0];
    assign direct    = (mod == 2'b00) && (rm == RM_DIRECT);
    assign use_index = !rm[2] || !rm[1];
    assign use_base  = (!rm[2] || rm[1]) && !direct;
    assign base_id   = ((rm[2:1] == 2'b01) || (rm == 3'b110)) ? REG_BP : REG_BX;

    assign regs.base_id  = base_id;
    assign regs.index_id = rm[0] ? REG_IY : REG_IX;

    // bp based forms default to ss
    assign ea_seg      = (use_base && (base_id == REG_BP)) ? SEG_SS : SEG_DS;
    assign regs.seg_id = exec_q ? ea_seg : instr.reg_id[SREG_ID_W-1:0];

    assign eff_addr  = (use_base ? regs.base_data : '0) + (use_index ? regs.index_data : '0)
                     + disp_q;
    assign phys_addr = {regs.seg_data, 4'h0} + {4'h0, eff_addr};

    // writeback, either a register move or the end of a bus read
    assign bus_finish   = (bus_command != BUS_IDLE) && bus_command_done;
    assign regs.we      = (exec_q && !mem_q) || (bus_finish && (bus_command == BUS_READ));
    assign regs.is_sreg = dst_kind_q == SRC_SREG;
    assign regs.wr_id   = dst_id_q;
    assign regs.wr_word = word_q;
    assign regs.wr_data = mem_q ? bus_data_in : src_val_q;

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            exec_q           <= 1'b0;
            bus_command      <= BUS_IDLE;
            instruction_done <= 1'b0;
        end
        else
        begin
            instruction_done <= 1'b0;
            if (transfer)
                exec_q <= 1'b1;
            if (exec_q)
            begin
                exec_q <= 1'b0;
                if (mem_q)
                    bus_command <= (dst_kind_q == SRC_MEM) ? BUS_WRITE : BUS_READ;
                else
                    instruction_done <= 1'b1;
            end
            if (bus_finish)
            begin
                bus_command      <= BUS_IDLE;
                instruction_done <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (transfer)
        begin
            word_q     <= instr.word;
            dst_kind_q <= instr.dst_kind;
            dst_id_q   <= instr.rm_id;
            mem_q      <= instr.mem;
            ea_mode_q  <= instr.ea_mode;
            disp_q     <= instr.disp;
            src_val_q  <= src_value;
        end
        // address and data stay put until the command completes
        if (exec_q && mem_q)
        begin
            bus_address  <= phys_addr;
            bus_data_out <= src_val_q;
            bus_word     <= word_q;
        end
    end

endmodule

// File: source/decode_stage.sv
`timescale 1ns/1ps

module decode_stage
    import isa_pkg::*;
(
    input  logic              clk,
    input  logic              reset,
    input  logic [BYTE_W-1:0] prefetch_data,
    input  logic              queue_empty,
    output logic              queue_pop,
    instr_if.driver           instr
);

    logic [2:0]        state;
    logic [2:0]        next_state;
    logic [7:0]        opcode_q;
    logic [7:0]        modrm_q;
    logic [DATA_W-1:0] disp_q;
    logic [DATA_W-1:0] imm_q;
    logic [7:0]        cur_opcode;
    logic [7:0]        cur_modrm;
    logic [1:0]        mod;
    logic [2:0]        reg_field;
    logic [2:0]        rm;
    logic              is_rm_r;
    logic              is_r_rm;
    logic              is_rm_sreg;
    logic              is_sreg_rm;
    logic              is_imm_r;
    logic              is_imm_rm;
    logic              is_mov;
    logic              need_modrm;
    logic              need_imm;
    logic              mem;
    logic              direct;
    logic              need_disp;
    logic              disp16;
    logic              word;
    logic              to_reg_field;
    logic [1:0]        reg_kind;
    logic [1:0]        rm_kind;
    logic              last_byte;

    // the byte being popped is decoded in the same cycle it is read
    assign cur_opcode = (state == FETCH_OPCODE) ? prefetch_data : opcode_q;
    assign cur_modrm  = (state == FETCH_MODRM) ? prefetch_data : modrm_q;
    assign mod        = cur_modrm[7:6];
    assign reg_field  = cur_modrm[5:3];
    assign rm         = cur_modrm[2:0];

    assign is_rm_r    = cur_opcode[7:1] == OPC_MOV_RM_R[7:1];
    assign is_r_rm    = cur_opcode[7:1] == OPC_MOV_R_RM[7:1];
    assign is_rm_sreg = cur_opcode == OPC_MOV_RM_SREG;
    assign is_sreg_rm = cur_opcode == OPC_MOV_SREG_RM;
    assign is_imm_r   = cur_opcode[7:4] == OPC_MOV_IMM_R[7:4];
    assign is_imm_rm  = cur_opcode[7:1] == OPC_MOV_IMM_RM[7:1];
    assign is_mov     = is_rm_r | is_r_rm | is_rm_sreg | is_sreg_rm | is_imm_r | is_imm_rm;
    assign need_modrm = is_mov && !is_imm_r;
    assign need_imm   = is_imm_r || is_imm_rm;

    // segment moves are always word sized
    assign word = is_imm_r ? cur_opcode[3] : (is_rm_sreg || is_sreg_rm || cur_opcode[0]);

    assign mem       = need_modrm && (mod != MOD_REG);
    assign direct    = (mod == 2'b00) && (rm == RM_DIRECT);
    assign need_disp = mem && ((mod != 2'b00) || direct);
    assign disp16    = (mod == 2'b10) || direct;

    // 8a/8e move from the rm side into the reg field
    assign to_reg_field = is_r_rm || is_sreg_rm;
    assign reg_kind     = (is_rm_sreg || is_sreg_rm) ? SRC_SREG : SRC_REG;
    assign rm_kind      = mem ? SRC_MEM : SRC_REG;

    always_comb
    begin
        case (state)
            FETCH_OPCODE:
                // anything outside the mov family is dropped here
                next_state = !is_mov ? FETCH_OPCODE :
                             (need_modrm ? FETCH_MODRM : FETCH_IMM_LO);
            FETCH_MODRM:
                next_state = need_disp ? FETCH_DISP_LO :
                             (need_imm ? FETCH_IMM_LO : FETCH_OPCODE);
            FETCH_DISP_LO:
                next_state = disp16 ? FETCH_DISP_HI :
                             (need_imm ? FETCH_IMM_LO : FETCH_OPCODE);
            FETCH_DISP_HI:
                next_state = need_imm ? FETCH_IMM_LO : FETCH_OPCODE;
            FETCH_IMM_LO:
                next_state = word ? FETCH_IMM_HI : FETCH_OPCODE;
            default:
                next_state = FETCH_OPCODE;
        endcase
    end

    // every mov is at least two bytes, so returning to opcode means complete
    assign last_byte = (state != FETCH_OPCODE) && (next_state == FETCH_OPCODE);

    // no pop while a finished instruction waits for execute
    assign queue_pop = !queue_empty && (!instr.valid || instr.ready);

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            state       <= FETCH_OPCODE;
            instr.valid <= 1'b0;
        end
        else
        begin
            if (instr.valid && instr.ready)
                instr.valid <= 1'b0;
            if (queue_pop)
            begin
                state <= next_state;
                if (last_byte)
                    instr.valid <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (queue_pop)
        begin
            case (state)
                FETCH_OPCODE:
                    opcode_q <= prefetch_data;
                FETCH_MODRM:
                begin
                    modrm_q <= prefetch_data;
                    disp_q  <= '0;
                end
                // disp8 is sign extended now and may be overwritten by disp16 high
                FETCH_DISP_LO:
                    disp_q <= {{8{prefetch_data[7]}}, prefetch_data};
                FETCH_DISP_HI:
                    disp_q[15:8] <= prefetch_data;
                FETCH_IMM_LO:
                    imm_q <= {8'h00, prefetch_data};
                default:
                    imm_q[15:8] <= prefetch_data;
            endcase
        end

        // operand fields are frozen on the last byte and held while valid
        if (queue_pop && last_byte)
        begin
            instr.word     <= word;
            instr.src_kind <= need_imm ? SRC_IMM : (to_reg_field ? rm_kind : reg_kind);
            instr.dst_kind <= to_reg_field ? reg_kind : rm_kind;
            instr.reg_id   <= to_reg_field ? rm : reg_field;
            instr.rm_id    <= to_reg_field ? reg_field : (is_imm_r ? cur_opcode[2:0] : rm);
            instr.mem      <= mem;
            instr.ea_mode  <= {mod, rm};
        end
    end

    assign instr.disp = disp_q;
    assign instr.imm  = imm_q;

endmodule

// File: source/regfile_if.sv
`timescale 1ns/1ps

interface regfile_if
    import isa_pkg::*;
();

    // read ids, data comes back in the same cycle
    logic [REG_ID_W-1:0]  src_id;
    logic [REG_ID_W-1:0]  base_id;
    logic [REG_ID_W-1:0]  index_id;
    logic [SREG_ID_W-1:0] seg_id;
    logic [DATA_W-1:0]    src_data;
    logic [DATA_W-1:0]    base_data;
    logic [DATA_W-1:0]    index_data;
    logic [DATA_W-1:0]    seg_data;

    // writeback, lands on the next rising edge
    logic                 we;
    logic                 is_sreg;
    logic [REG_ID_W-1:0]  wr_id;
    logic                 wr_word;
    logic [DATA_W-1:0]    wr_data;

    modport driver   (output src_id, base_id, index_id, seg_id, we, is_sreg, wr_id, wr_word,
                      wr_data, input src_data, base_data, index_data, seg_data);
    modport receiver (input src_id, base_id, index_id, seg_id, we, is_sreg, wr_id, wr_word,
                      wr_data, output src_data, base_data, index_data, seg_data);

endinterface

// File: source/instr_if.sv
`timescale 1ns/1ps

interface instr_if
    import isa_pkg::*;
();

    // transfer on a rising edge with valid and ready both high
    logic                valid;
    logic                ready;
    logic                word;
    logic [1:0]          src_kind;
    logic [1:0]          dst_kind;
    // reg_id names the source register, rm_id the destination register
    logic [REG_ID_W-1:0] reg_id;
    logic [REG_ID_W-1:0] rm_id;
    // modrm names memory, ea_mode is {mod, rm}
    logic                mem;
    logic [4:0]          ea_mode;
    // disp is already sign extended, zero when the form has none
    logic [DATA_W-1:0]   disp;
    logic [DATA_W-1:0]   imm;

    modport driver   (output valid, word, src_kind, dst_kind, reg_id, rm_id, mem, ea_mode,
                      disp, imm, input ready);
    modport receiver (input valid, word, src_kind, dst_kind, reg_id, rm_id, mem, ea_mode,
                      disp, imm, output ready);

endinterface

// File: source/bus_pkg.sv
package bus_pkg;

    // 20-bit physical address, segment * 16 + offset
    localparam int ADDR_W = 20;

    // bus command codes, held until bus_command_done
    localparam logic [1:0] BUS_IDLE  = 2'd0;
    localparam logic [1:0] BUS_READ  = 2'd1;
    localparam logic [1:0] BUS_WRITE = 2'd2;

endpackage

// File: source/isa_pkg.sv
package isa_pkg;

    // operand width and prefetch queue byte width
    localparam int DATA_W    = 16;
    localparam int BYTE_W    = 8;
    localparam int REG_ID_W  = 3;
    localparam int SREG_ID_W = 2;

    // mov opcodes with the w bit (and the register for b0..bf) masked off
    localparam logic [7:0] OPC_MOV_RM_R    = 8'h88;  // r -> r/m
    localparam logic [7:0] OPC_MOV_R_RM    = 8'h8a;  // r/m -> r
    localparam logic [7:0] OPC_MOV_RM_SREG = 8'h8c;  // sreg -> r/m
    localparam logic [7:0] OPC_MOV_SREG_RM = 8'h8e;  // r/m -> sreg
    localparam logic [7:0] OPC_MOV_IMM_R   = 8'hb0;  // imm -> r, bit 3 is w
    localparam logic [7:0] OPC_MOV_IMM_RM  = 8'hc6;  // imm -> r/m

    // modrm encodings
    localparam logic [1:0] MOD_REG   = 2'b11;
    // with mod 00 this rm means a bare disp16 address
    localparam logic [2:0] RM_DIRECT = 3'b110;

    // word registers that take part in address generation
    localparam logic [2:0] REG_BX = 3'd3;
    localparam logic [2:0] REG_BP = 3'd5;
    localparam logic [2:0] REG_IX = 3'd6;
    localparam logic [2:0] REG_IY = 3'd7;

    // default segments, ss whenever bp forms the address
    localparam logic [1:0] SEG_SS = 2'd2;
    localparam logic [1:0] SEG_DS = 2'd3;

    // operand kinds shared by decode and execute
    localparam logic [1:0] SRC_REG  = 2'd0;
    localparam logic [1:0] SRC_MEM  = 2'd1;
    localparam logic [1:0] SRC_IMM  = 2'd2;
    localparam logic [1:0] SRC_SREG = 2'd3;

    // position of the next byte within an instruction
    localparam logic [2:0] FETCH_OPCODE  = 3'd0;
    localparam logic [2:0] FETCH_MODRM   = 3'd1;
    localparam logic [2:0] FETCH_DISP_LO = 3'd2;
    localparam logic [2:0] FETCH_DISP_HI = 3'd3;
    localparam logic [2:0] FETCH_IMM_LO  = 3'd4;
    localparam logic [2:0] FETCH_IMM_HI  = 3'd5;

endpackage
